/* pw_pkg.sv */
package pw_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int PW_DATA_W            = 8;   // register bus and fe data
   localparam int PW_TRIG_DELAY_W      = 16;
   localparam int PW_TRIG_WIDTH_W      = 8;
   localparam int PW_NUM_TRIG_W        = 4;
   localparam int PW_PATTERN_BYTES_DEF = 8;   // up to 16, one address window

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////

   typedef enum logic [PW_DATA_W-1:0] {
      REG_ARM           = 8'h00,  // bit 0 arms the matcher
      REG_SPEED         = 8'h01,
      REG_PAT_LEN       = 8'h02,
      REG_TRIG_DELAY_LO = 8'h03,
      REG_TRIG_DELAY_HI = 8'h04,
      REG_TRIG_WIDTH    = 8'h05,
      REG_NUM_TRIG      = 8'h06,
      REG_STATUS        = 8'h07,  // {busy, arm}, read only
      REG_PATTERN_BASE  = 8'h10,  // 16 byte window
      REG_MASK_BASE     = 8'h20   // 16 byte window
   } reg_addr_e;

   // upper nibble selects the pattern and mask windows
   localparam logic [PW_DATA_W-1:0] REG_WINDOW_MASK = 8'hF0;

   ////////////////////////////////////////
   // front end speed
   ////////////////////////////////////////

   // no autodetect here, AUTO decodes like FS
   typedef enum logic [1:0] {
      SPEED_FS   = 2'd0,
      SPEED_LS   = 2'd1,
      SPEED_HS   = 2'd2,
      SPEED_AUTO = 2'd3
   } usb_speed_e;

   ////////////////////////////////////////
   // trigger fsm
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      TRIG_IDLE,
      TRIG_DELAY,   // low time before each pulse
      TRIG_PULSE
   } trig_state_e;

endpackage

/* pw_cfg_if.sv */
`timescale 1ns/1ps

interface pw_cfg_if
   import pw_pkg::*;
#(
   parameter int PATTERN_BYTES = PW_PATTERN_BYTES_DEF
) ();

   logic                                      arm;
   logic [PATTERN_BYTES-1:0][PW_DATA_W-1:0]   pattern;   // byte 0 is the oldest
   logic [PATTERN_BYTES-1:0][PW_DATA_W-1:0]   mask;      // 1 = compare this bit
   logic [PW_DATA_W-1:0]                      pat_len;
   logic [PW_TRIG_DELAY_W-1:0]                trig_delay;
   logic [PW_TRIG_WIDTH_W-1:0]                trig_width;
   logic [PW_NUM_TRIG_W-1:0]                  num_trig;
   logic                                      trig_busy;
   logic                                      trig_done; // one cycle, end of train

   modport regs (
      output arm, pattern, mask, pat_len, trig_delay, trig_width, num_trig,
      input  trig_busy, trig_done
   );

   modport matcher (
      input arm, pattern, mask, pat_len, trig_busy
   );

   modport trigger (
      input  trig_delay, trig_width, num_trig,
      output trig_busy, trig_done
   );

endinterface

/* pw_regs.sv */
`timescale 1ns/1ps

module pw_regs
   import pw_pkg::*;
#(
   parameter int PATTERN_BYTES = PW_PATTERN_BYTES_DEF
) (
   input  logic                 fe_clk_i,
   input  logic                 rst_n_i,
   input  logic [PW_DATA_W-1:0] reg_addr_i,
   input  logic [PW_DATA_W-1:0] reg_wdata_i,
   input  logic                 reg_write_i,
   input  logic                 reg_read_i,
   output logic [PW_DATA_W-1:0] reg_rdata_o,
   output logic [1:0]           fe_xcvrsel_o,
   output logic                 fe_termsel_o,
   pw_cfg_if.regs               cfg
);

   logic                                    arm_q;
   usb_speed_e                              speed_q;
   logic [PW_DATA_W-1:0]                    pat_len_q;
   logic [PW_TRIG_DELAY_W-1:0]              trig_delay_q;
   logic [PW_TRIG_WIDTH_W-1:0]              trig_width_q;
   logic [PW_NUM_TRIG_W-1:0]                num_trig_q;
   logic [PATTERN_BYTES-1:0][PW_DATA_W-1:0] pattern_q;
   logic [PATTERN_BYTES-1:0][PW_DATA_W-1:0] mask_q;
   logic [PW_DATA_W-1:0]                    rdata_q;
   logic [PW_DATA_W-1:0]                    rdata_mux;

   logic [3:0] win_idx;
   logic       win_valid;
   logic       pat_sel;
   logic       mask_sel;

   ////////////////////////////////////////
   // address decode
   ////////////////////////////////////////

   assign win_idx   = reg_addr_i[3:0];
   assign win_valid = ({1'b0, win_idx} < PATTERN_BYTES); // bytes past the depth do not exist
   assign pat_sel   = win_valid && ((reg_addr_i & REG_WINDOW_MASK) == REG_PATTERN_BASE);
   assign mask_sel  = win_valid && ((reg_addr_i & REG_WINDOW_MASK) == REG_MASK_BASE);

   ////////////////////////////////////////
   // write side
   ////////////////////////////////////////

   always_ff @(posedge fe_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         arm_q        <= 1'b0;
         speed_q      <= SPEED_FS;
         pat_len_q    <= '0;
         trig_delay_q <= '0;
         trig_width_q <= '0;
         num_trig_q   <= '0;
         pattern_q    <= '0;
         mask_q       <= '0;
      end else begin
         if (reg_write_i && reg_addr_i == REG_ARM) begin
            arm_q <= reg_wdata_i[0];
         end else if (cfg.trig_done) begin
            arm_q <= 1'b0;   // one arm, one train
         end

         if (reg_write_i) begin
            case (reg_addr_i)
               REG_SPEED:         speed_q <= usb_speed_e'(reg_wdata_i[1:0]);
               REG_PAT_LEN:       pat_len_q <= reg_wdata_i;
               REG_TRIG_DELAY_LO: trig_delay_q[7:0] <= reg_wdata_i;
               REG_TRIG_DELAY_HI: trig_delay_q[15:8] <= reg_wdata_i;
               REG_TRIG_WIDTH:    trig_width_q <= reg_wdata_i;
               REG_NUM_TRIG:      num_trig_q <= reg_wdata_i[PW_NUM_TRIG_W-1:0];
               default: begin
                  for (int i = 0; i < PATTERN_BYTES; i++) begin
                     if (pat_sel && win_idx == i) pattern_q[i] <= reg_wdata_i;
                     if (mask_sel && win_idx == i) mask_q[i] <= reg_wdata_i;
                  end
               end
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // read side
   ////////////////////////////////////////

   always_comb begin
      rdata_mux = '0;
      case (reg_addr_i)
         REG_ARM:           rdata_mux = {7'd0, arm_q};
         REG_SPEED:         rdata_mux = {6'd0, speed_q};
         REG_PAT_LEN:       rdata_mux = pat_len_q;
         REG_TRIG_DELAY_LO: rdata_mux = trig_delay_q[7:0];
         REG_TRIG_DELAY_HI: rdata_mux = trig_delay_q[15:8];
         REG_TRIG_WIDTH:    rdata_mux = trig_width_q;
         REG_NUM_TRIG:      rdata_mux = {4'd0, num_trig_q};
         REG_STATUS:        rdata_mux = {6'd0, cfg.trig_busy, arm_q};
         default: begin
            for (int i = 0; i < PATTERN_BYTES; i++) begin
               if (pat_sel && win_idx == i) rdata_mux = pattern_q[i];
               if (mask_sel && win_idx == i) rdata_mux = mask_q[i];
            end
         end
      endcase
   end

   always_ff @(posedge fe_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rdata_q <= '0;
      end else if (reg_read_i) begin
         rdata_q <= rdata_mux;   // held until the next read
      end
   end

   assign reg_rdata_o = rdata_q;

   // front end select follows the speed register directly
   always_comb begin
      case (speed_q)
         SPEED_LS: begin
            fe_xcvrsel_o = 2'b10;
            fe_termsel_o = 1'b1;
         end
         SPEED_HS: begin
            fe_xcvrsel_o = 2'b00;
            fe_termsel_o = 1'b0;
         end
         default: begin           // FS and AUTO
            fe_xcvrsel_o = 2'b01;
            fe_termsel_o = 1'b1;
         end
      endcase
   end

   assign cfg.arm        = arm_q;
   assign cfg.pattern    = pattern_q;
   assign cfg.mask       = mask_q;
   assign cfg.pat_len    = pat_len_q;
   assign cfg.trig_delay = trig_delay_q;
   assign cfg.trig_width = trig_width_q;
   assign cfg.num_trig   = num_trig_q;

   a_no_rd_wr_collision: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i) !(reg_read_i && reg_write_i)
   );

endmodule

/* pw_pattern_matcher.sv */
`timescale 1ns/1ps

module pw_pattern_matcher
   import pw_pkg::*;
#(
   parameter int PATTERN_BYTES = PW_PATTERN_BYTES_DEF
) (
   input  logic                 fe_clk_i,
   input  logic                 rst_n_i,
   input  logic [PW_DATA_W-1:0] fe_data_i,
   input  logic                 fe_rxvalid_i,
   pw_cfg_if.matcher            cfg,
   output logic                 match_o
);

   // hist_q[0] is the newest accepted byte
   logic [PATTERN_BYTES-1:0][PW_DATA_W-1:0] hist_q;
   logic                                    new_byte_q;
   logic                                    match_q;
   logic [PW_DATA_W-1:0]                    len_eff;
   logic                                    hit;

   ////////////////////////////////////////
   // byte history
   ////////////////////////////////////////

   always_ff @(posedge fe_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hist_q     <= '0;
         new_byte_q <= 1'b0;
      end else begin
         new_byte_q <= fe_rxvalid_i;   // compare once per accepted byte
         if (fe_rxvalid_i) begin
            hist_q[0] <= fe_data_i;
            for (int j = 1; j < PATTERN_BYTES; j++) begin
               hist_q[j] <= hist_q[j-1];
            end
         end
      end
   end

   ////////////////////////////////////////
   // masked compare
   ////////////////////////////////////////

   // oversized lengths clip to the history depth
   assign len_eff = (cfg.pat_len > PATTERN_BYTES) ? PW_DATA_W'(PATTERN_BYTES) : cfg.pat_len;

   always_comb begin
      logic [PW_DATA_W-1:0] pidx;
      hit  = (len_eff != '0);   // empty pattern never matches
      pidx = '0;
      for (int j = 0; j < PATTERN_BYTES; j++) begin
         if (j < len_eff) begin
            // age j lines up with pattern byte len-1-j
            pidx = len_eff - PW_DATA_W'(j) - 1'b1;
            if (((hist_q[j] ^ cfg.pattern[pidx]) & cfg.mask[pidx]) != '0) begin
               hit = 1'b0;
            end
         end
      end
   end

   // one cycle pulse, only while armed and the trigger is idle
   always_ff @(posedge fe_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         match_q <= 1'b0;
      end else begin
         match_q <= new_byte_q && hit && cfg.arm && !cfg.trig_busy;
      end
   end

   assign match_o = match_q;

   // the arm flag is what keeps a finished train from retriggering
   a_match_needs_arm: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i) match_o |-> $past(cfg.arm)
   );

endmodule

/* pw_trigger.sv */
`timescale 1ns/1ps

module pw_trigger
   import pw_pkg::*;
(
   input  logic        fe_clk_i,
   input  logic        rst_n_i,
   input  logic        match_i,
   pw_cfg_if.trigger   cfg,
   output logic        trig_o
);

   trig_state_e                 state_q;
   logic [PW_TRIG_DELAY_W-1:0]  delay_cnt_q;
   logic [PW_TRIG_WIDTH_W-1:0]  width_cnt_q;
   logic [PW_NUM_TRIG_W-1:0]    pulse_cnt_q;   // pulses finished so far
   logic                        trig_q;
   logic                        done_q;
   logic [PW_TRIG_WIDTH_W-1:0]  width_eff;
   logic [PW_NUM_TRIG_W-1:0]    num_eff;
   logic                        last_pulse;

   // zero width or count means one
   assign width_eff  = (cfg.trig_width == '0) ? PW_TRIG_WIDTH_W'(1) : cfg.trig_width;
   assign num_eff    = (cfg.num_trig == '0) ? PW_NUM_TRIG_W'(1) : cfg.num_trig;
   assign last_pulse = (pulse_cnt_q == num_eff - 1'b1);

   ////////////////////////////////////////
   // pulse train fsm
   ////////////////////////////////////////

   always_ff @(posedge fe_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= TRIG_IDLE;
         delay_cnt_q <= '0;
         width_cnt_q <= '0;
         pulse_cnt_q <= '0;
         trig_q      <= 1'b0;
         done_q      <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            TRIG_IDLE: begin
               if (match_i) begin
                  pulse_cnt_q <= '0;
                  if (cfg.trig_delay == '0) begin
                     state_q     <= TRIG_PULSE;   // no delay, rise right away
                     trig_q      <= 1'b1;
                     width_cnt_q <= width_eff - 1'b1;
                  end else begin
                     state_q     <= TRIG_DELAY;
                     delay_cnt_q <= cfg.trig_delay - 1'b1;   // first rise at match + 1 + delay
                  end
               end
            end

            TRIG_DELAY: begin
               if (delay_cnt_q == '0) begin
                  state_q     <= TRIG_PULSE;
                  trig_q      <= 1'b1;
                  width_cnt_q <= width_eff - 1'b1;
               end else begin
                  delay_cnt_q <= delay_cnt_q - 1'b1;
               end
            end

            TRIG_PULSE: begin
               if (width_cnt_q != '0) begin
                  width_cnt_q <= width_cnt_q - 1'b1;
               end else if (last_pulse) begin
                  trig_q  <= 1'b0;
                  done_q  <= 1'b1;
                  state_q <= TRIG_IDLE;
               end else if (cfg.trig_delay == '0) begin
                  // no gap, next pulse runs straight on
                  pulse_cnt_q <= pulse_cnt_q + 1'b1;
                  width_cnt_q <= width_eff - 1'b1;
               end else begin
                  trig_q      <= 1'b0;
                  pulse_cnt_q <= pulse_cnt_q + 1'b1;
                  delay_cnt_q <= cfg.trig_delay - 1'b1;  // exactly delay low cycles
                  state_q     <= TRIG_DELAY;
               end
            end

            default: state_q <= TRIG_IDLE;
         endcase
      end
   end

   assign trig_o        = trig_q;
   assign cfg.trig_done = done_q;
   // busy covers the done cycle too, arm is still high then
   assign cfg.trig_busy = (state_q != TRIG_IDLE) || done_q;

   a_trig_in_busy: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i) trig_o |-> cfg.trig_busy
   );

   a_done_single: assert property (
      @(posedge fe_clk_i) disable iff (!rst_n_i) cfg.trig_done |=> !cfg.trig_done
   );

endmodule

/* pw_top.sv */
`timescale 1ns/1ps

module pw_top
   import pw_pkg::*;
#(
   parameter int PATTERN_BYTES = PW_PATTERN_BYTES_DEF
) (
   input  logic                 fe_clk_i,
   input  logic                 rst_n_i,
   // host register bus
   input  logic [PW_DATA_W-1:0] reg_addr_i,
   input  logic [PW_DATA_W-1:0] reg_wdata_i,
   input  logic                 reg_write_i,
   input  logic                 reg_read_i,
   output logic [PW_DATA_W-1:0] reg_rdata_o,
   // front end
   input  logic [PW_DATA_W-1:0] fe_data_i,
   input  logic                 fe_rxvalid_i,
   output logic [1:0]           fe_xcvrsel_o,
   output logic                 fe_termsel_o,
   // trigger and leds
   output logic                 trig_o,
   output logic                 led_cap_o,
   output logic                 led_trig_o
);

   logic match;

   pw_cfg_if #(.PATTERN_BYTES(PATTERN_BYTES)) u_cfg_if ();

   pw_regs #(
      .PATTERN_BYTES (PATTERN_BYTES)
   ) u_regs (
      .fe_clk_i     (fe_clk_i),
      .rst_n_i      (rst_n_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_write_i  (reg_write_i),
      .reg_read_i   (reg_read_i),
      .reg_rdata_o  (reg_rdata_o),
      .fe_xcvrsel_o (fe_xcvrsel_o),
      .fe_termsel_o (fe_termsel_o),
      .cfg          (u_cfg_if.regs)
   );

   pw_pattern_matcher #(
      .PATTERN_BYTES (PATTERN_BYTES)
   ) u_pattern_matcher (
      .fe_clk_i     (fe_clk_i),
      .rst_n_i      (rst_n_i),
      .fe_data_i    (fe_data_i),
      .fe_rxvalid_i (fe_rxvalid_i),
      .cfg          (u_cfg_if.matcher),
      .match_o      (match)
   );

   pw_trigger u_trigger (
      .fe_clk_i (fe_clk_i),
      .rst_n_i  (rst_n_i),
      .match_i  (match),
      .cfg      (u_cfg_if.trigger),
      .trig_o   (trig_o)
   );

   assign led_cap_o  = u_cfg_if.arm;
   assign led_trig_o = u_cfg_if.trig_busy;

endmodule

/* tb_pw_top.sv */
`timescale 1ns/1ps

module tb_pw_top;
   import pw_pkg::*;

   localparam int NUM_TESTS  = 5;
   localparam int FILL_BYTES = 6;
   localparam int KEEP_ARM   = 2;   // arm flag value that leaves REG_ARM untouched

   logic       fe_clk_i;
   logic       rst_n_i;
   logic [7:0] reg_addr_i;
   logic [7:0] reg_wdata_i;
   logic       reg_write_i;
   logic       reg_read_i;
   logic [7:0] reg_rdata_o;
   logic [7:0] fe_data_i;
   logic       fe_rxvalid_i;
   logic [1:0] fe_xcvrsel_o;
   logic       fe_termsel_o;
   logic       trig_o;
   logic       led_cap_o;
   logic       led_trig_o;

   // stimulus table, byte 0 sits in the low bits
   logic [1:0]  t_speed   [NUM_TESTS];
   logic [63:0] t_pattern [NUM_TESTS];
   logic [63:0] t_mask    [NUM_TESTS];
   int          t_len     [NUM_TESTS];
   int          t_delay   [NUM_TESTS];
   int          t_width   [NUM_TESTS];
   int          t_num     [NUM_TESTS];
   int          t_arm     [NUM_TESTS];
   logic [63:0] t_stream  [NUM_TESTS];   // first byte sent in the low bits
   int          t_slen    [NUM_TESTS];
   int          t_exp     [NUM_TESTS];   // expected pulse count

   integer seed        = 35;
   int     edge_cnt    = 0;
   int     err_cnt     = 0;
   int     pass_cnt    = 0;
   int     fail_cnt    = 0;
   int     accept_edge = 0;
   logic   trig_prev   = 1'b0;
   logic   table_ready = 1'b0;
   logic   exp_arm     = 1'b0;
   int     rise_q[$];
   int     fall_q[$];

   pw_top #(.PATTERN_BYTES(PW_PATTERN_BYTES_DEF)) u_pw_top (.*);

   initial fe_clk_i = 1'b0;
   always #20 fe_clk_i = ~fe_clk_i;

   always @(posedge fe_clk_i) edge_cnt <= edge_cnt + 1;

   ////////////////////////////////////////
   // pulse monitor
   ////////////////////////////////////////

   always @(negedge fe_clk_i) begin
      if (rst_n_i) begin
         if (trig_o && !trig_prev) rise_q.push_back(edge_cnt);   // edge that raised it
         if (!trig_o && trig_prev) fall_q.push_back(edge_cnt);
         if (trig_o && !led_trig_o) report_error("led_trig_o", 1, led_trig_o);
         trig_prev = trig_o;
      end
   end

   task automatic report_error(input string name, input int exp, input int act);
      $display("error at %0t: %s expected %0h got %0h", $time, name, exp, act);
      err_cnt++;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      @(negedge fe_clk_i);
      reg_addr_i  = addr;
      reg_wdata_i = data;
      reg_write_i = 1'b1;
      @(negedge fe_clk_i);
      reg_write_i = 1'b0;
   endtask

   // data is registered on the read edge and held afterwards
   task automatic read_check(input logic [7:0] addr, input logic [7:0] exp, input string name);
      @(negedge fe_clk_i);
      reg_addr_i = addr;
      reg_read_i = 1'b1;
      @(negedge fe_clk_i);
      reg_read_i = 1'b0;
      if (reg_rdata_o !== exp) report_error(name, exp, reg_rdata_o);
   endtask

   task automatic set_entry(input int i, input logic [1:0] sp, input logic [63:0] pat,
                            input logic [63:0] msk, input int len, input int dly,
                            input int wid, input int num, input int arm,
                            input logic [63:0] stream, input int slen, input int exp);
      t_speed[i]   = sp;
      t_pattern[i] = pat;
      t_mask[i]    = msk;
      t_len[i]     = len;
      t_delay[i]   = dly;
      t_width[i]   = wid;
      t_num[i]     = num;
      t_arm[i]     = arm;
      t_stream[i]  = stream;
      t_slen[i]    = slen;
      t_exp[i]     = exp;
   endtask

   task automatic load_table();
      // exact match, three pulses
      set_entry(0, 2'd0, 64'h04030201, 64'hFFFFFFFF, 4, 3, 2, 3, 1, 64'h04030201, 4, 3);
      // same match again, arm not renewed
      set_entry(1, 2'd1, 64'h04030201, 64'hFFFFFFFF, 4, 3, 2, 3, KEEP_ARM, 64'h04030201, 4, 0);
      // low nibble masked off, width 0 acts as 1
      set_entry(2, 2'd2, 64'h44332211, 64'hF0F0F0F0, 4, 5, 0, 2, 1, 64'h4D3C2B1A, 4, 2);
      // bit 4 of the last byte differs under the mask
      set_entry(3, 2'd3, 64'h44332211, 64'hF0F0F0F0, 4, 2, 1, 1, 1, 64'h5D3C2B1A, 4, 0);
      set_entry(4, 2'd0, 64'h04030201, 64'hFFFFFFFF, 4, 1, 1, 1, 0, 64'h04030201, 4, 0);
   endtask

   task automatic send_bytes(input int t);
      logic [31:0] rnd;
      for (int k = 0; k < FILL_BYTES; k++) begin
         @(negedge fe_clk_i);
         rnd          = $random(seed);
         fe_data_i    = rnd[7:0] | 8'h80;   // bit 7 set, never matches
         fe_rxvalid_i = 1'b1;
      end
      for (int k = 0; k < t_slen[t]; k++) begin
         @(negedge fe_clk_i);
         fe_data_i    = t_stream[t][k*8 +: 8];
         fe_rxvalid_i = 1'b1;
         accept_edge  = edge_cnt + 1;
      end
      @(negedge fe_clk_i);
      fe_rxvalid_i = 1'b0;
   endtask

   ////////////////////////////////////////
   // one table entry
   ////////////////////////////////////////

   task automatic run_test(input int t);
      int         errs_before;
      int         w_eff;
      int         lim;
      int         waited;
      int         exp_rise;
      logic       seen_busy;
      logic [1:0] xs;
      logic       ts;
      errs_before = err_cnt;
      w_eff       = (t_width[t] == 0) ? 1 : t_width[t];
      if (t_arm[t] != KEEP_ARM) begin
         write_reg(REG_ARM, 8'h00);   // disarmed while reconfiguring
         exp_arm = 1'b0;
      end
      write_reg(REG_SPEED, {6'd0, t_speed[t]});
      write_reg(REG_PAT_LEN, t_len[t]);
      write_reg(REG_TRIG_DELAY_LO, t_delay[t] % 256);
      write_reg(REG_TRIG_DELAY_HI, t_delay[t] / 256);
      write_reg(REG_TRIG_WIDTH, t_width[t]);
      write_reg(REG_NUM_TRIG, t_num[t]);
      for (int i = 0; i < t_len[t]; i++) begin
         write_reg(8'(REG_PATTERN_BASE + i), t_pattern[t][i*8 +: 8]);
         write_reg(8'(REG_MASK_BASE + i), t_mask[t][i*8 +: 8]);
      end
      read_check(REG_SPEED, {6'd0, t_speed[t]}, "REG_SPEED");
      read_check(REG_PAT_LEN, t_len[t], "REG_PAT_LEN");
      read_check(REG_TRIG_DELAY_LO, t_delay[t] % 256, "REG_TRIG_DELAY_LO");
      read_check(REG_TRIG_DELAY_HI, t_delay[t] / 256, "REG_TRIG_DELAY_HI");
      read_check(REG_TRIG_WIDTH, t_width[t], "REG_TRIG_WIDTH");
      read_check(REG_NUM_TRIG, t_num[t], "REG_NUM_TRIG");
      for (int i = 0; i < t_len[t]; i++) begin
         read_check(8'(REG_PATTERN_BASE + i), t_pattern[t][i*8 +: 8], "pattern byte");
         read_check(8'(REG_MASK_BASE + i), t_mask[t][i*8 +: 8], "mask byte");
      end

      // LS 10/1, HS 00/0, FS and AUTO 01/1
      case (t_speed[t])
         2'd1: begin
            xs = 2'b10;
            ts = 1'b1;
         end
         2'd2: begin
            xs = 2'b00;
            ts = 1'b0;
         end
         default: begin
            xs = 2'b01;
            ts = 1'b1;
         end
      endcase
      if (fe_xcvrsel_o !== xs) report_error("fe_xcvrsel_o", xs, fe_xcvrsel_o);
      if (fe_termsel_o !== ts) report_error("fe_termsel_o", ts, fe_termsel_o);

      if (t_arm[t] == 1) begin
         write_reg(REG_ARM, 8'h01);
         exp_arm = 1'b1;
      end
      read_check(REG_STATUS, {7'd0, exp_arm}, "REG_STATUS");
      read_check(REG_ARM, {7'd0, exp_arm}, "REG_ARM");
      if (led_cap_o !== exp_arm) report_error("led_cap_o", exp_arm, led_cap_o);

      @(posedge fe_clk_i);
      rise_q.delete();
      fall_q.delete();
      send_bytes(t);

      // wait for busy to rise and fall, or the window to run out
      seen_busy = 1'b0;
      waited    = 0;
      lim       = 16 * (t_delay[t] + w_eff + 2) + 20;
      while (waited < lim && !(seen_busy && !led_trig_o)) begin
         @(negedge fe_clk_i);
         if (led_trig_o) seen_busy = 1'b1;
         waited++;
      end
      if (t_exp[t] > 0 && waited >= lim) begin
         $display("test %0d: trigger train did not finish within %0d cycles", t, lim);
         err_cnt++;
      end

      if (rise_q.size() != t_exp[t]) report_error("trig_o pulse count", t_exp[t], rise_q.size());
      for (int k = 0; k < rise_q.size(); k++) begin
         if (k == 0 || k - 1 < fall_q.size()) begin
            exp_rise = (k == 0) ? accept_edge + 2 + t_delay[t] : fall_q[k-1] + t_delay[t];
            if (rise_q[k] != exp_rise) report_error("trig_o rise edge", exp_rise, rise_q[k]);
         end
         if (k < fall_q.size()) begin
            if (fall_q[k] - rise_q[k] != w_eff) begin
               report_error("trig_o pulse width", w_eff, fall_q[k] - rise_q[k]);
            end
         end
      end

      if (t_exp[t] > 0) begin
         exp_arm = 1'b0;   // done drops arm
         if (led_cap_o !== 1'b0) report_error("led_cap_o", 0, led_cap_o);
         read_check(REG_STATUS, 8'h00, "REG_STATUS");
      end

      if (err_cnt == errs_before) pass_cnt++;
      else fail_cnt++;
      $display("test %0d speed %0d pulses %0d of %0d: %s", t, t_speed[t], rise_q.size(),
               t_exp[t], (err_cnt == errs_before) ? "pass" : "fail");
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      int errs_before;
      rst_n_i      = 1'b0;
      reg_addr_i   = '0;
      reg_wdata_i  = '0;
      reg_write_i  = 1'b0;
      reg_read_i   = 1'b0;
      fe_data_i    = '0;
      fe_rxvalid_i = 1'b0;
      load_table();
      table_ready = 1'b1;
      repeat (10) @(posedge fe_clk_i);
      @(negedge fe_clk_i);
      rst_n_i = 1'b1;

      errs_before = err_cnt;
      read_check(REG_STATUS, 8'h00, "REG_STATUS");
      if (fe_xcvrsel_o !== 2'b01) report_error("fe_xcvrsel_o", 2'b01, fe_xcvrsel_o);
      if (fe_termsel_o !== 1'b1) report_error("fe_termsel_o", 1, fe_termsel_o);
      if (trig_o !== 1'b0) report_error("trig_o", 0, trig_o);
      if (led_cap_o !== 1'b0) report_error("led_cap_o", 0, led_cap_o);
      if (err_cnt == errs_before) pass_cnt++;
      else fail_cnt++;
      $display("reset values: %s", (err_cnt == errs_before) ? "pass" : "fail");

      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end

      $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // watchdog, sized from the table
   initial begin
      int limit;
      wait (table_ready);
      limit = 300;
      for (int i = 0; i < NUM_TESTS; i++) begin
         limit += t_slen[i] + 16 * (t_delay[i] + t_width[i] + 2) + 200;
      end
      repeat (limit) @(posedge fe_clk_i);
      $display("watchdog expired after %0d cycles, the run did not finish", limit);
      $display("TB FAILED");
      $finish;
   end

endmodule

/* filelist.f */
pw_pkg.sv
pw_cfg_if.sv
pw_regs.sv
pw_pattern_matcher.sv
pw_trigger.sv
pw_top.sv
tb_pw_top.sv

/* Bender.yml */
package:
  name: pw_trigger

sources:
  - pw_pkg.sv
  - pw_cfg_if.sv
  - pw_regs.sv
  - pw_pattern_matcher.sv
  - pw_trigger.sv
  - pw_top.sv
  - target: test
    files:
      - tb_pw_top.sv
